/* build.f */
src/fx_pkg.sv
src/partial_products.sv
src/delay_line.sv
src/fx_mult.sv
src/fx_accum.sv
src/fx_mac.sv
tests/fx_mac_chk.sv
tests/fx_mac_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the fx_mac testbench, the log decides the result
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module fx_mac_tb -Mdir obj_dir -f build.f \
    || { echo "verilator build failed"; exit 1; }

./obj_dir/Vfx_mac_tb +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log

grep -q "Some tests failed" sim.log && exit 1
grep -q "All tests passed" sim.log || exit 1
exit 0

/* src/delay_line.sv */
`timescale 1ns/1ns
`default_nettype none

module delay_line #(
    parameter int WIDTH = 1,
    parameter int DEPTH = 1
) (
    input  wire              clk,
    input  wire              rst_n,
    input  wire  [WIDTH-1:0] d,
    output logic [WIDTH-1:0] q
);

    logic [WIDTH-1:0] stage [DEPTH];

    // stage 0 takes d, each later stage takes its neighbour
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int k = 0; k < DEPTH; k++) begin
                stage[k] <= '0;
            end
        end else begin
            stage[0] <= d;
            for (int k = 1; k < DEPTH; k++) begin
                stage[k] <= stage[k-1];
            end
        end
    end

    assign q = stage[DEPTH-1];

endmodule

`default_nettype wire

/* src/fx_accum.sv */
`timescale 1ns/1ns
`default_nettype none

module fx_accum (
    input  wire                           clk,
    input  wire                           rst_n,
    input  wire                           product_valid,
    input  wire  [fx_pkg::data_width-1:0] product,
    input  wire                           acc_clear,
    output logic [fx_pkg::acc_width-1:0]  acc,
    output logic                          acc_valid
);

    localparam int aw  = fx_pkg::acc_width;
    localparam int pad = fx_pkg::acc_width - fx_pkg::mag_width;

    logic signed [aw-1:0] mag_ext;
    logic signed [aw-1:0] addend;
    logic signed [aw-1:0] base;
    logic signed [aw:0]   total;
    logic signed [aw-1:0] next_acc;

    ////////////////////////////////////////
    // sign-magnitude to two's complement
    ////////////////////////////////////////

    always_comb begin
        mag_ext = {{pad{1'b0}}, product[fx_pkg::mag_width-1:0]};
        addend  = product[fx_pkg::data_width-1] ? -mag_ext : mag_ext;

        // clear starts the sum from zero instead of the old value
        base  = acc_clear ? '0 : acc;
        total = {base[aw-1], base} + {addend[aw-1], addend};

        // top two bits differ on overflow
        if (total[aw] != total[aw-1]) begin
            next_acc = total[aw] ? fx_pkg::acc_min : fx_pkg::acc_max;
        end else begin
            next_acc = total[aw-1:0];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc       <= '0;
            acc_valid <= 1'b0;
        end else begin
            acc_valid <= product_valid;
            if (product_valid) begin
                acc <= next_acc;
            end else if (acc_clear) begin
                acc <= '0;
            end
        end
    end

endmodule

`default_nettype wire

/* src/fx_mac.sv */
`timescale 1ns/1ns
`default_nettype none

module fx_mac (
    input  wire                           clk,
    input  wire                           rst_n,
    input  wire                           valid_in,
    input  wire  [fx_pkg::data_width-1:0] a,
    input  wire  [fx_pkg::data_width-1:0] b,
    input  wire                           acc_clear,
    output logic [fx_pkg::data_width-1:0] product,
    output logic                          product_valid,
    output logic [fx_pkg::acc_width-1:0]  acc,
    output logic                          acc_valid
);

    ////////////////////////////////////////
    // multiplier, tree_depth cycles
    ////////////////////////////////////////

    fx_mult mult0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .valid_in  (valid_in),
        .a         (a),
        .b         (b),
        .valid_out (product_valid),
        .product   (product)
    );

    ////////////////////////////////////////
    // accumulator, one more cycle
    ////////////////////////////////////////

    // product also leaves the top for observation
    fx_accum accum0 (
        .clk           (clk),
        .rst_n         (rst_n),
        .product_valid (product_valid),
        .product       (product),
        .acc_clear     (acc_clear),
        .acc           (acc),
        .acc_valid     (acc_valid)
    );

endmodule

`default_nettype wire

/* src/fx_mult.sv */
`timescale 1ns/1ns
`default_nettype none

module fx_mult (
    input  wire                            clk,
    input  wire                            rst_n,
    input  wire                            valid_in,
    input  wire  [fx_pkg::data_width-1:0]  a,
    input  wire  [fx_pkg::data_width-1:0]  b,
    output logic                           valid_out,
    output logic [fx_pkg::data_width-1:0]  product
);

    localparam int n_leaf = fx_pkg::data_width;
    localparam int msb    = fx_pkg::data_width - 1;

    logic [fx_pkg::pp_width-1:0] pp [n_leaf];

    // heap order, node k adds nodes 2k and 2k+1, node 1 is the root
    logic [fx_pkg::pp_width-1:0] sum [1:n_leaf-1];

    logic sign_in;
    logic sign_out;

    ////////////////////////////////////////
    // partial products of the magnitudes
    ////////////////////////////////////////

    partial_products pp_gen (
        .mag_a (a[fx_pkg::mag_width-1:0]),
        .mag_b (b[fx_pkg::mag_width-1:0]),
        .pp    (pp)
    );

    ////////////////////////////////////////
    // registered binary adder tree
    ////////////////////////////////////////

    genvar k;
    generate
        for (k = 1; k < n_leaf; k++) begin : node_g
            logic [fx_pkg::pp_width-1:0] lhs;
            logic [fx_pkg::pp_width-1:0] rhs;

            if (k >= n_leaf / 2) begin : leaf_g
                // first level reads the partial products directly
                assign lhs = pp[2*k - n_leaf];
                assign rhs = pp[2*k + 1 - n_leaf];
            end else begin : inner_g
                assign lhs = sum[2*k];
                assign rhs = sum[2*k + 1];
            end

            // sum wraps at pp_width bits
            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    sum[k] <= '0;
                end else begin
                    sum[k] <= lhs + rhs;
                end
            end
        end
    endgenerate

    ////////////////////////////////////////
    // sign and valid follow the tree
    ////////////////////////////////////////

    assign sign_in = a[msb] ^ b[msb];

    delay_line #(
        .WIDTH (1),
        .DEPTH (fx_pkg::tree_depth)
    ) valid_dly (
        .clk   (clk),
        .rst_n (rst_n),
        .d     (valid_in),
        .q     (valid_out)
    );

    delay_line #(
        .WIDTH (1),
        .DEPTH (fx_pkg::tree_depth)
    ) sign_dly (
        .clk   (clk),
        .rst_n (rst_n),
        .d     (sign_in),
        .q     (sign_out)
    );

    // drop the low fraction bits, product is truncated
    assign product = {sign_out, sum[1][fx_pkg::pp_width-1:fx_pkg::frac_bits]};

endmodule

`default_nettype wire

/* src/fx_pkg.sv */
`default_nettype none

package fx_pkg;

    ////////////////////////////////////////
    // operand format, sign-magnitude Q15.16
    ////////////////////////////////////////

    localparam int data_width = 32;
    localparam int int_part   = 15;
    localparam int frac_bits  = data_width - 1 - int_part;
    localparam int mag_width  = data_width - 1;

    // every partial product and tree node is this wide
    localparam int pp_width   = 2 * mag_width - int_part;

    // one registered adder level per halving of the partial products
    localparam int tree_depth = $clog2(data_width);

    ////////////////////////////////////////
    // accumulator, two's complement
    ////////////////////////////////////////

    localparam int acc_width  = 40;

    localparam logic signed [acc_width-1:0] acc_max = {1'b0, {(acc_width-1){1'b1}}};
    localparam logic signed [acc_width-1:0] acc_min = {1'b1, {(acc_width-1){1'b0}}};

endpackage

`default_nettype wire

/* src/partial_products.sv */
`timescale 1ns/1ns
`default_nettype none

module partial_products (
    input  wire  [fx_pkg::mag_width-1:0] mag_a,
    input  wire  [fx_pkg::mag_width-1:0] mag_b,
    output logic [fx_pkg::pp_width-1:0]  pp [fx_pkg::data_width]
);

    localparam int full_width = 2 * fx_pkg::mag_width;

    ////////////////////////////////////////
    // one shifted copy of mag_a per bit of mag_b
    ////////////////////////////////////////

    genvar i;
    generate
        for (i = 0; i < fx_pkg::data_width; i++) begin : pp_g
            if (i < fx_pkg::mag_width) begin : cell_g
                logic [full_width-1:0] shifted;

                // widen first so no bits fall off before truncation
                assign shifted = {{fx_pkg::mag_width{1'b0}}, mag_a} << i;

                // keep only the low pp_width bits, high bits wrap away
                assign pp[i] = mag_b[i] ? shifted[fx_pkg::pp_width-1:0] : '0;
            end else begin : pad_g
                // pads the tree up to a power of two leaves
                assign pp[i] = '0;
            end
        end
    endgenerate

endmodule

`default_nettype wire

/* tests/fx_mac_chk.sv */
`timescale 1ns/1ns
`default_nettype none

module fx_mac_chk (
    input wire clk,
    input wire rst_n,
    input wire valid_in,
    input wire product_valid,
    input wire acc_valid
);

    int fail_count = 0;

    ////////////////////////////////////////
    // pipeline timing
    ////////////////////////////////////////

    // gaps in valid_in come out as gaps too
    product_timing: assert property (@(posedge clk) disable iff (!rst_n)
        product_valid == $past(valid_in, fx_pkg::tree_depth)) else begin
        $error("product_valid is not valid_in delayed by the tree depth");
        fail_count++;
    end

    acc_timing: assert property (@(posedge clk) disable iff (!rst_n)
        acc_valid == $past(product_valid)) else begin
        $error("acc_valid is not product_valid delayed by one cycle");
        fail_count++;
    end

    reset_quiet: assert property (@(posedge clk)
        !rst_n |-> (!product_valid && !acc_valid)) else begin
        $error("valid output high during reset");
        fail_count++;
    end

endmodule

bind fx_mac fx_mac_chk chk0 (
    .clk           (clk),
    .rst_n         (rst_n),
    .valid_in      (valid_in),
    .product_valid (product_valid),
    .acc_valid     (acc_valid)
);

`default_nettype wire

/* tests/fx_mac_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module fx_mac_tb;

    localparam int dw          = fx_pkg::data_width;
    localparam int aw          = fx_pkg::acc_width;
    localparam int lat         = fx_pkg::tree_depth;
    localparam int n_random    = 200;
    localparam int n_gap_slots = 40;
    localparam int n_sat       = 270;

    // rough length of all tests in cycles, run may take twice that
    localparam int test_cycles = 8 + 20 + n_random + n_gap_slots + 2 * n_sat + 120;
    localparam int max_cycles  = 2 * test_cycles;

    logic          clk;
    logic          rst_n;
    logic          valid_in;
    logic [dw-1:0] a;
    logic [dw-1:0] b;
    logic          acc_clear;
    logic [dw-1:0] product;
    logic          product_valid;
    logic [aw-1:0] acc;
    logic          acc_valid;

    // expected values and the cycle they are due in
    logic [dw-1:0]        prod_q [$];
    int                   prod_due_q [$];
    logic signed [aw-1:0] acc_q [$];
    int                   acc_due_q [$];

    logic                 pend_valid = 1'b0;
    logic [dw-1:0]        pend_prod  = '0;
    logic signed [aw-1:0] model_acc  = '0;
    logic [31:0]          rng_state  = 32'hd9ffff73;
    int                   cycle      = 0;
    int                   value_errors    = 0;
    int                   protocol_errors = 0;

    fx_mac dut0 (
        .clk           (clk),
        .rst_n         (rst_n),
        .valid_in      (valid_in),
        .a             (a),
        .b             (b),
        .acc_clear     (acc_clear),
        .product       (product),
        .product_valid (product_valid),
        .acc           (acc),
        .acc_valid     (acc_valid)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    ////////////////////////////////////////
    // reference model
    ////////////////////////////////////////

    function automatic logic [31:0] next_random();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // full magnitude product, then keep bits 46 down to 16
    function automatic logic [dw-1:0] model_product(input logic [dw-1:0] x,
                                                    input logic [dw-1:0] y);
        logic [2*fx_pkg::mag_width-1:0] full;
        full = {{fx_pkg::mag_width{1'b0}}, x[dw-2:0]} * {{fx_pkg::mag_width{1'b0}}, y[dw-2:0]};
        return {x[dw-1] ^ y[dw-1], full[fx_pkg::pp_width-1:fx_pkg::frac_bits]};
    endfunction

    function automatic logic signed [aw-1:0] signed_value(input logic [dw-1:0] p);
        logic signed [aw-1:0] m;
        m = {{(aw-dw+1){1'b0}}, p[dw-2:0]};
        return p[dw-1] ? -m : m;
    endfunction

    function automatic logic signed [aw-1:0] add_clamped(input logic signed [aw-1:0] x,
                                                         input logic signed [aw-1:0] y);
        logic signed [aw:0] s;
        s = (aw+1)'(x) + (aw+1)'(y);
        if (s > (aw+1)'(fx_pkg::acc_max)) return fx_pkg::acc_max;
        if (s < (aw+1)'(fx_pkg::acc_min)) return fx_pkg::acc_min;
        return s[aw-1:0];
    endfunction

    // accumulator model steps on the same edge as the DUT
    always @(posedge clk) begin
        cycle++;
        if (!rst_n) begin
            model_acc  = '0;
            pend_valid = 1'b0;
        end else if (pend_valid) begin
            model_acc = add_clamped(acc_clear ? '0 : model_acc, signed_value(pend_prod));
            acc_q.push_back(model_acc);
            acc_due_q.push_back(cycle);
            pend_valid = 1'b0;
        end else if (acc_clear) begin
            model_acc = '0;
        end
    end

    always @(negedge clk) begin : output_monitor
        logic [dw-1:0]        exp_p;
        logic signed [aw-1:0] exp_a;
        if (rst_n) begin
            if (prod_due_q.size() != 0 && prod_due_q[0] == cycle) begin
                exp_p = prod_q.pop_front();
                prod_due_q.delete(0);
                pend_prod  = exp_p;
                pend_valid = 1'b1;
                assert (product_valid) else begin
                    $display("product_valid missing at cycle %0d", cycle);
                    protocol_errors++;
                end
                if (product_valid) assert (product === exp_p) else begin
                    $display("[FAIL] product: expected %h, got %h", exp_p, product);
                    value_errors++;
                end
            end else assert (!product_valid) else begin
                $display("unexpected product_valid at cycle %0d", cycle);
                protocol_errors++;
            end
            if (acc_due_q.size() != 0 && acc_due_q[0] == cycle) begin
                exp_a = acc_q.pop_front();
                acc_due_q.delete(0);
                assert (acc_valid) else begin
                    $display("acc_valid missing at cycle %0d", cycle);
                    protocol_errors++;
                end
                if (acc_valid) assert (acc === exp_a) else begin
                    $display("[FAIL] acc: expected %h, got %h", exp_a, acc);
                    value_errors++;
                end
            end else assert (!acc_valid) else begin
                $display("unexpected acc_valid at cycle %0d", cycle);
                protocol_errors++;
            end
        end
    end

    ////////////////////////////////////////
    // stimulus helpers, entered after a falling edge
    ////////////////////////////////////////

    task automatic issue(input logic [dw-1:0] x, input logic [dw-1:0] y);
        valid_in = 1'b1;
        a        = x;
        b        = y;
        prod_q.push_back(model_product(x, y));
        prod_due_q.push_back(cycle + lat);
        @(negedge clk);
        valid_in = 1'b0;
    endtask

    task automatic wait_drained();
        while (prod_q.size() != 0 || pend_valid || acc_q.size() != 0) @(negedge clk);
        @(negedge clk);
    endtask

    task automatic clear_acc();
        acc_clear = 1'b1;
        @(negedge clk);
        acc_clear = 1'b0;
        assert (acc === '0) else begin
            $display("[FAIL] acc: expected %h, got %h", {aw{1'b0}}, acc);
            value_errors++;
        end
    endtask

    ////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////

    task automatic check_reset();
        assert (!product_valid && !acc_valid) else begin
            $display("a valid output is high right after reset");
            protocol_errors++;
        end
        assert (acc === '0) else begin
            $display("[FAIL] acc: expected %h, got %h", {aw{1'b0}}, acc);
            value_errors++;
        end
    endtask

    task automatic test_directed();
        issue(32'h0001_0000, 32'h0001_0000);
        issue(32'h0002_8000, 32'h8003_0000);
        issue(32'h0000_0000, 32'h1234_5678);
        issue(32'h8000_0000, 32'h0001_0000);
        wait_drained();
    endtask

    // back to back, five products in flight
    task automatic test_random();
        logic [dw-1:0] x;
        logic [dw-1:0] y;
        for (int i = 0; i < n_random; i++) begin
            x = next_random();
            y = next_random();
            issue(x, y);
        end
        wait_drained();
    endtask

    task automatic test_gaps();
        logic [31:0] r;
        for (int i = 0; i < n_gap_slots; i++) begin
            r = next_random();
            if (r[7]) begin
                issue(next_random(), next_random());
            end else begin
                @(negedge clk);
            end
        end
        wait_drained();
    endtask

    task automatic test_accumulate();
        clear_acc();
        issue(32'h0003_0000, 32'h0002_0000);
        issue(32'h8001_8000, 32'h0004_0000);
        issue(32'h0000_4000, 32'h8008_0000);
        wait_drained();
        // +32767.0 per product, saturates high
        repeat (n_sat) issue(32'h7fff_0000, 32'h0001_0000);
        wait_drained();
        clear_acc();
        repeat (n_sat) issue(32'hffff_0000, 32'h0001_0000);
        wait_drained();
    endtask

    task automatic test_clear();
        int            due;
        logic [dw-1:0] exp_p;
        issue(32'h0003_0000, 32'h0002_0000);
        wait_drained();
        clear_acc();
        issue(32'h0003_0000, 32'h0002_0000);
        wait_drained();
        // clear lands on the edge that takes the product
        due   = cycle + lat;
        exp_p = model_product(32'h0001_8000, 32'h8002_0000);
        issue(32'h0001_8000, 32'h8002_0000);
        while (cycle < due) @(negedge clk);
        acc_clear = 1'b1;
        @(negedge clk);
        acc_clear = 1'b0;
        wait_drained();
        assert (acc === signed_value(exp_p)) else begin
            $display("[FAIL] acc: expected %h, got %h", signed_value(exp_p), acc);
            value_errors++;
        end
    endtask

    initial begin
        wait (cycle >= max_cycles);
        $display("timeout after %0d cycles", cycle);
        $display("Some tests failed");
        $finish;
    end

    initial begin
        rst_n     = 1'b0;
        valid_in  = 1'b0;
        a         = '0;
        b         = '0;
        acc_clear = 1'b0;
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        check_reset();
        test_directed();
        test_random();
        test_gaps();
        test_accumulate();
        test_clear();
        $display("value errors: %0d, protocol errors: %0d, timing assertion errors: %0d",
                 value_errors, protocol_errors, dut0.chk0.fail_count);
        if (value_errors + protocol_errors + dut0.chk0.fail_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
